/* rv32i_pipe.f */
+incdir+rtl
rtl/rv32i_isa_pkg.sv
rtl/rv32i_pipe_pkg.sv
rtl/rv32i_decoder.sv
rtl/rv32i_regfile.sv
rtl/rv32i_execute.sv
rtl/rv32i_hazard.sv
rtl/rv32i_pipe.sv
bench/rv32i_pipe_sva.sv
bench/rv32i_checker.sv
bench/tb_rv32i_pipe.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rv32i_pipe -Mdir obj_dir -f rv32i_pipe.f

output=$(./obj_dir/Vtb_rv32i_pipe 2>&1) || true
echo "$output"

if grep -qF 'All tests passed!' <<< "$output"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

/* bench/rv32i_cases.mem */
// Columns: kind, a, b (hex). Kind 1 puts instruction b at byte address a,
// kind 2 expects the next store to write b to address a
// Dependent arithmetic at distances one and two
1 00000000 00c00093
1 00000004 00a08113
1 00000008 002081b3
1 0000000c 10302023
1 00000010 40308233
1 00000014 002272b3
1 00000018 0012e333
1 0000001c 004343b3
1 00000020 10702223
1 00000024 00531433
1 00000028 02f47493
1 0000002c 1014e513
1 00000030 fff54593
1 00000034 00459613
1 00000038 10c02423
// Load followed by a dependent add
1 0000003c 10802683
1 00000040 00168733
1 00000044 10e02623
// Taken beq over two markers, then a not-taken bne
1 00000048 00210663
1 0000004c 10102823
1 00000050 10102823
1 00000054 00109463
1 00000058 10202823
// jal with link in x15 over two markers
1 0000005c 00c007ef
1 00000060 10102a23
1 00000064 10102a23
1 00000068 10f02a23
// Write x0, store x0, then spin
1 0000006c 06300013
1 00000070 10002c23
1 00000074 0000006f
// Expected stores in order
2 00000100 00000022
2 00000104 ffffffe4
2 00000108 ffffed60
2 0000010c ffffed6c
2 00000110 00000016
2 00000114 00000060
2 00000118 00000000

/* bench/tb_rv32i_pipe.sv */
// Testbench top for the RV32I pipeline, loads the program and expected stores from the case file
`timescale 1ns/1ns
`include "rv32i_consts.svh"

module tb_rv32i_pipe
  import rv32i_isa_pkg::*;
();

  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int CASE_WORDS = 192;   // Room for 64 records
  localparam int MAX_STORES = 64;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  word_t pc;
  word_t inst;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  word_t imem [IMEM_WORDS];
  word_t dmem [DMEM_WORDS];
  word_t cases [CASE_WORDS];
  word_t exp_addr [MAX_STORES];
  word_t exp_data [MAX_STORES];
  int    exp_count = 0;
  int    prog_words = 0;
  int    load_errors = 0;
  logic  loaded = 1'b0;

  logic  done;
  int    mismatches;
  int    other_errors;

  always #4 clk = ~clk;

  rv32i_pipe uut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .inst      (inst),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  // Both memories answer within the cycle
  assign inst      = imem[pc[9:2]];
  assign mem_rdata = dmem[mem_addr[9:2]];

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= 32'hd000_0000 | (i << 2);   // Each word holds its own address
    end
    else if (mem_write)
      dmem[mem_addr[9:2]] <= mem_wdata;
  end

  rv32i_checker #(
    .MAX_STORES (MAX_STORES)
  ) u_checker (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .mem_write    (mem_write),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .exp_addr     (exp_addr),
    .exp_data     (exp_data),
    .exp_count    (exp_count),
    .done         (done),
    .mismatches   (mismatches),
    .other_errors (other_errors)
  );

  task automatic load_cases();
    int i;
    for (i = 0; i < IMEM_WORDS; i++)
      imem[i] = `RV_NOP;
    for (i = 0; i < CASE_WORDS; i++)
      cases[i] = '0;
    $readmemh("bench/rv32i_cases.mem", cases);
    for (i = 0; i + 2 < CASE_WORDS && cases[i] != 32'd0; i += 3)
    begin
      if (cases[i] == 32'd1)
      begin
        imem[cases[i + 1][9:2]] = cases[i + 2];
        prog_words++;
      end
      else if (cases[i] == 32'd2 && exp_count < MAX_STORES)
      begin
        exp_addr[exp_count] = cases[i + 1];
        exp_data[exp_count] = cases[i + 2];
        exp_count++;
      end
      else
      begin
        $display("ERROR: bad record of kind %0h at word %0d of the case file", cases[i], i);
        load_errors++;
      end
    end
    if (prog_words == 0 || exp_count == 0)
    begin
      $display("ERROR: the case file holds no program or no expected stores");
      load_errors++;
    end
    loaded = 1'b1;
  endtask

  task automatic report_counts(input int timeouts);
    $display("Summary: %0d mismatches, %0d other errors, %0d case file errors, %0d timeouts",
             mismatches, other_errors, load_errors, timeouts);
  endtask

  initial
  begin
    load_cases();
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    wait (done);
    report_counts(0);
    if (mismatches + other_errors + load_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog scaled by program length
  initial
  begin
    wait (loaded);
    repeat (prog_words * 10 + 100) @(posedge clk);
    if (!done)
    begin
      $display("TIMEOUT at %0t: the program did not finish within %0d cycles",
               $time, prog_words * 10 + 100);
      report_counts(1);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

/* bench/rv32i_checker.sv */
// Store and pc checker for the pipeline testbench, compares each data-memory write with the expected list
`timescale 1ns/1ns
`include "rv32i_consts.svh"

module rv32i_checker
  import rv32i_isa_pkg::*;
#(
  parameter int MAX_STORES   = 64,
  parameter int DRAIN_CYCLES = 20
)
(
  input  logic  clk,
  input  logic  reset,
  input  word_t pc,
  input  logic  mem_write,
  input  word_t mem_addr,
  input  word_t mem_wdata,
  input  word_t exp_addr [MAX_STORES],
  input  word_t exp_data [MAX_STORES],
  input  int    exp_count,
  output logic  done,
  output int    mismatches,
  output int    other_errors
);

  int   store_idx = 0;        // Next expected store
  int   drain = 0;
  int   mismatch_count = 0;
  int   error_count = 0;
  logic finished = 1'b0;
  logic pc_checked = 1'b0;

  assign done         = finished;
  assign mismatches   = mismatch_count;
  assign other_errors = error_count;

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  task automatic check_store();
    if (store_idx >= exp_count)
    begin
      $display("ERROR at %0t: unexpected store of %h to address %h",
               $time, mem_wdata, mem_addr);
      error_count++;
    end
    else
    begin
      compare_word("mem_addr", exp_addr[store_idx], mem_addr);
      compare_word("mem_wdata", exp_data[store_idx], mem_wdata);
    end
    store_idx++;
  endtask

  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (!pc_checked)
      begin
        compare_word("pc", `RV_RESET_PC, pc);   // First cycle out of reset
        pc_checked = 1'b1;
      end
      if ($isunknown(mem_write))
      begin
        $display("ERROR at %0t: mem_write is unknown", $time);
        error_count++;
      end
      else if (mem_write)
        check_store();
      // Keep watching for stray stores after the last expected one
      if (store_idx >= exp_count && !finished)
      begin
        drain++;
        if (drain >= DRAIN_CYCLES)
          finished = 1'b1;
      end
    end
  end

endmodule

/* bench/rv32i_pipe_sva.sv */
// Concurrent assertions on the pipeline top level, attached to every rv32i_pipe by the bind below
`timescale 1ns/1ns

module rv32i_pipe_sva
  import rv32i_isa_pkg::*;
(
  input logic  clk,
  input logic  reset,
  input word_t pc,
  input logic  mem_write,
  input logic  stall,
  input logic  flush
);

  // Reset clears the stage registers at the first edge, so sample half a cycle later
  reset_no_store: assert property (@(negedge clk) reset |-> !mem_write)
    else $error("store issued while reset is high");

  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

  stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
                                   (stall && !flush) |=> $stable(pc))
    else $error("pc moved during a load-use stall");

  store_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(mem_write))
    else $error("mem_write is unknown after reset");

endmodule

bind rv32i_pipe rv32i_pipe_sva u_sva (
  .clk       (clk),
  .reset     (reset),
  .pc        (pc),
  .mem_write (mem_write),
  .stall     (stall),
  .flush     (flush)
);

/* rtl/rv32i_pipe.sv */
// Top level of the five-stage RV32I pipeline, holds the pc and stage registers and drives memory ports
`timescale 1ns/1ns
`include "rv32i_consts.svh"

module rv32i_pipe
  import rv32i_isa_pkg::*, rv32i_pipe_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  output word_t pc,
  input  word_t inst,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_wdata,
  input  word_t mem_rdata
);

  // Fetch to decode
  logic     fd_valid;
  word_t    fd_pc;
  word_t    fd_inst;

  ctrl_t    dec_ctrl;
  reg_idx_t dec_rs1;
  reg_idx_t dec_rs2;
  reg_idx_t dec_rd;
  word_t    dec_imm;
  word_t    rf_a;
  word_t    rf_b;

  dec_exe_t dex;
  exe_mem_t xm_next;
  exe_mem_t xm;
  mem_wb_t  mw;

  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     stall;
  logic     flush;
  logic     redirect;
  word_t    target;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= `RV_RESET_PC;
    else if (flush)
      pc <= target;   // Flush beats stall
    else if (!stall)
      pc <= pc + `RV_PC_STEP;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fd_valid <= 1'b0;
      fd_inst  <= `RV_NOP;
    end
    else if (flush)
    begin
      fd_valid <= 1'b0;
      fd_inst  <= `RV_NOP;
    end
    else if (!stall)
    begin
      fd_valid <= 1'b1;
      fd_inst  <= inst;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      fd_pc <= pc;
  end

  rv32i_decoder u_decoder (
    .inst (fd_inst),
    .ctrl (dec_ctrl),
    .rs1  (dec_rs1),
    .rs2  (dec_rs2),
    .rd   (dec_rd),
    .imm  (dec_imm)
  );

  rv32i_regfile u_regfile (
    .clk     (clk),
    .reset   (reset),
    .we      (mw.valid & mw.reg_write),
    .waddr   (mw.rd),
    .wdata   (mw.wb_data),
    .raddr_a (dec_rs1),
    .raddr_b (dec_rs2),
    .rdata_a (rf_a),
    .rdata_b (rf_b)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      dex <= '0;
    else if (flush || stall)
    begin
      dex.valid <= 1'b0;   // Bubble into execute
      dex.ctrl  <= '0;
    end
    else
    begin
      dex.valid    <= fd_valid;
      dex.ctrl     <= fd_valid ? dec_ctrl : '0;
      dex.pc       <= fd_pc;
      dex.rs1      <= dec_rs1;
      dex.rs2      <= dec_rs2;
      dex.rd       <= dec_rd;
      dex.rs1_data <= rf_a;
      dex.rs2_data <= rf_b;
      dex.imm      <= dec_imm;
    end
  end

  rv32i_hazard u_hazard (
    .rs1      (dec_rs1),
    .rs2      (dec_rs2),
    .dex      (dex),
    .xm       (xm),
    .mw       (mw),
    .redirect (redirect),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b),
    .stall    (stall),
    .flush    (flush)
  );

  rv32i_execute u_execute (
    .dex        (dex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_result (xm.result),
    .wb_data    (mw.wb_data),
    .xm         (xm_next),
    .redirect   (redirect),
    .target     (target)
  );

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      xm <= '0;
      mw <= '0;
    end
    else
    begin
      xm         <= xm_next;
      mw.valid   <= xm.valid;
      mw.reg_write <= xm.reg_write;
      mw.rd      <= xm.rd;
      mw.wb_data <= xm.mem_read ? mem_rdata : xm.result;   // Loaded word or ALU result
    end
  end

  assign mem_write = xm.mem_write;
  assign mem_addr  = xm.result;
  assign mem_wdata = xm.store_data;

endmodule

/* rtl/rv32i_hazard.sv */
// Hazard unit, picks forwarding sources for execute and raises load-use stall and redirect flush
`timescale 1ns/1ns

module rv32i_hazard
  import rv32i_isa_pkg::*, rv32i_pipe_pkg::*;
(
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  dec_exe_t dex,
  input  exe_mem_t xm,
  input  mem_wb_t  mw,
  input  logic     redirect,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output logic     stall,
  output logic     flush
);

  // Youngest producer first
  function automatic fwd_sel_t fwd_for(input reg_idx_t src, input exe_mem_t m,
                                       input mem_wb_t w);
    fwd_sel_t sel;
    if (m.valid && m.reg_write && m.rd != '0 && m.rd == src)
      sel = FWD_MEM;
    else if (w.valid && w.reg_write && w.rd != '0 && w.rd == src)
      sel = FWD_WB;
    else
      sel = FWD_NONE;
    return sel;
  endfunction

  assign fwd_a = fwd_for(dex.rs1, xm, mw);
  assign fwd_b = fwd_for(dex.rs2, xm, mw);

  // Loaded word is not ready until writeback
  assign stall = dex.valid & dex.ctrl.mem_read & (dex.rd != '0) &
                 ((dex.rd == rs1) | (dex.rd == rs2));

  assign flush = redirect;

endmodule

/* rtl/rv32i_execute.sv */
// Execute stage logic, forwards operands, runs the ALU and resolves branches and jal
`timescale 1ns/1ns
`include "rv32i_consts.svh"

module rv32i_execute
  import rv32i_isa_pkg::*, rv32i_pipe_pkg::*;
(
  input  dec_exe_t dex,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  word_t    mem_result,
  input  word_t    wb_data,
  output exe_mem_t xm,
  output logic     redirect,
  output word_t    target
);

  word_t op_a;
  word_t op_b_reg;   // Forwarded rs2, also the store data
  word_t op_b;
  word_t alu_res;
  logic  zero;
  logic  taken;

  function automatic word_t pick(input fwd_sel_t sel, input word_t reg_val,
                                 input word_t mem_val, input word_t wb_val);
    word_t val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;
    endcase
    return val;
  endfunction

  assign op_a     = pick(fwd_a, dex.rs1_data, mem_result, wb_data);
  assign op_b_reg = pick(fwd_b, dex.rs2_data, mem_result, wb_data);
  assign op_b     = dex.ctrl.alu_src_imm ? dex.imm : op_b_reg;

  always_comb
  begin
    case (dex.ctrl.alu_op)
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_OR:  alu_res = op_a | op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      ALU_SLL: alu_res = op_a << op_b[4:0];
      default: alu_res = op_a + op_b;
    endcase
  end

  assign zero     = (alu_res == '0);
  assign taken    = dex.ctrl.branch & (dex.ctrl.branch_ne ? !zero : zero);
  assign redirect = dex.valid & (dex.ctrl.jal | taken);
  assign target   = dex.pc + dex.imm;   // Same adder for branch and jal

  always_comb
  begin
    xm.valid      = dex.valid;
    xm.reg_write  = dex.valid & dex.ctrl.reg_write;
    xm.mem_read   = dex.valid & dex.ctrl.mem_read;
    xm.mem_write  = dex.valid & dex.ctrl.mem_write;
    xm.rd         = dex.rd;
    xm.result     = dex.ctrl.jal ? dex.pc + `RV_PC_STEP : alu_res;   // Link value for jal
    xm.store_data = op_b_reg;
  end

endmodule

/* rtl/rv32i_regfile.sv */
// Register file with two read ports and a write-through bypass, read in decode and written from writeback
`timescale 1ns/1ns

module rv32i_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [4:0]  raddr_a,
  input  logic [4:0]  raddr_b,
  input  logic [31:0] wdata,
  output logic [31:0] rdata_a,
  output logic [31:0] rdata_b
);

  logic [31:0] regs [1:31];   // x0 has no storage

  function automatic logic [31:0] read_port(input logic [4:0] addr);
    logic [31:0] data;
    if (addr == 5'd0)
      data = '0;
    else if (we && addr == waddr)
      data = wdata;           // Same-cycle write wins
    else
      data = regs[addr];
    return data;
  endfunction

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && waddr != 5'd0)
      regs[waddr] <= wdata;
  end

  always_comb
  begin
    rdata_a = read_port(raddr_a);
    rdata_b = read_port(raddr_b);
  end

endmodule

/* rtl/rv32i_decoder.sv */
// Combinational decoder used in decode to turn a fetched word into control, indices and immediate
`timescale 1ns/1ns
`include "rv32i_consts.svh"

module rv32i_decoder
  import rv32i_isa_pkg::*, rv32i_pipe_pkg::*;
(
  input  word_t    inst,
  output ctrl_t    ctrl,
  output reg_idx_t rs1,
  output reg_idx_t rs2,
  output reg_idx_t rd,
  output word_t    imm
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  always_comb
  begin
    ctrl = '0;
    imm  = '0;
    case (opcode)
      `RV_OP_R:
      begin
        ctrl.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'd0, `RV_F3_ADD}:       ctrl.alu_op = ALU_ADD;
          {`RV_F7_SUB, `RV_F3_ADD}: ctrl.alu_op = ALU_SUB;
          {7'd0, `RV_F3_AND}:       ctrl.alu_op = ALU_AND;
          {7'd0, `RV_F3_OR}:        ctrl.alu_op = ALU_OR;
          {7'd0, `RV_F3_XOR}:       ctrl.alu_op = ALU_XOR;
          {7'd0, `RV_F3_SLL}:       ctrl.alu_op = ALU_SLL;
          default:                  ctrl = '0;
        endcase
      end
      `RV_OP_IMM:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          `RV_F3_ADD: ctrl.alu_op = ALU_ADD;
          `RV_F3_AND: ctrl.alu_op = ALU_AND;
          `RV_F3_OR:  ctrl.alu_op = ALU_OR;
          `RV_F3_XOR: ctrl.alu_op = ALU_XOR;
          `RV_F3_SLL: ctrl.alu_op = ALU_SLL;
          default:    ctrl = '0;
        endcase
        if (funct3 == `RV_F3_SLL && funct7 != 7'd0)
          ctrl = '0;   // slli needs a zero upper field
      end
      `RV_OP_LOAD:
      begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      `RV_OP_STORE:
      begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      `RV_OP_BRANCH:
      begin
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (funct3 == `RV_F3_BEQ || funct3 == `RV_F3_BNE)
        begin
          ctrl.branch    = 1'b1;
          ctrl.branch_ne = (funct3 == `RV_F3_BNE);
          ctrl.alu_op    = ALU_SUB;   // Zero difference means equal
        end
      end
      `RV_OP_JAL:
      begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* rtl/rv32i_pipe_pkg.sv */
// Control bundle and stage register structs, imported by the decoder, execute, hazard and top level
package rv32i_pipe_pkg;
  import rv32i_isa_pkg::*;

  // Decoded control, all zero for an unknown instruction
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    alu_src_imm;   // Second operand is the immediate
    logic    branch;
    logic    branch_ne;     // Taken on nonzero difference
    logic    jal;
    alu_op_t alu_op;
  } ctrl_t;

  // Decode to execute
  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    pc;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
  } dec_exe_t;

  // Execute to memory
  typedef struct packed {
    logic     valid;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    reg_idx_t rd;
    word_t    result;       // ALU result, address or link value
    word_t    store_data;
  } exe_mem_t;

  // Memory to writeback
  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_idx_t rd;
    word_t    wb_data;
  } mem_wb_t;

  // Operand source in execute
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

endpackage

/* rtl/rv32i_isa_pkg.sv */
// Instruction-set types shared by the pipeline modules, imported where words or fields are used
package rv32i_isa_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register index in the 32-entry file
  typedef logic [4:0] reg_idx_t;

  typedef logic [6:0] opcode_t;   // Low seven bits of an instruction

  // ALU operations of the kept instructions
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,   // Also used for the branch compare
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL
  } alu_op_t;

endpackage

/* rtl/rv32i_consts.svh */
// Encoding constants for the RV32I subset, included by the decoder, execute unit and top level
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Opcode field values
`define RV_OP_R       7'b0110011
`define RV_OP_IMM     7'b0010011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111

// Funct3 values
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_XOR     3'b100
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001

`define RV_F7_SUB     7'b0100000   // Selects sub over add

`define RV_NOP        32'h00000013 // addi x0, x0, 0
`define RV_RESET_PC   32'h00000000
`define RV_PC_STEP    32'd4

`endif
